// File: Bender.yml
package:
  name: pim_dma

sources:
  - source/pim_dma_pkg.sv
  - source/pim_cmd_capture.sv
  - source/sram_port.sv
  - source/pim_port.sv
  - source/pim_dma_sequencer.sv
  - source/pim_dma_top.sv
  - target: test
    files:
      - verification/tb_pim_dma.sv

// File: source/pim_cmd_capture.sv
module pim_cmd_capture import pim_dma_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     start_i,
    input  pim_op_e  funct3_i,
    input  word_t    rs1_i,
    input  word_t    rs2_i,
    output dma_cmd_t cmd_o,
    output count_t   words_o
);

    pim_op_e op_q;
    count_t  words_q;
    word_t   rc_addr_q;
    word_t   operand_q;

    // opcode and word count steer the sequencer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            op_q    <= NO_OP;
            words_q <= '0;
        end else if (start_i) begin
            op_q <= funct3_i;
            case (funct3_i)
                ERASE, PROGRAM, READ, ZERO_POINT: words_q <= count_t'(1);
                PARALLEL: words_q <= count_t'(PARALLEL_WORDS);
                default: words_q <= '0;
            endcase
        end
    end

    // address and operand only
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rc_addr_q <= rs1_i;
            operand_q <= rs2_i;
        end
    end

    assign cmd_o = '{op: op_q, rc_addr: rc_addr_q, operand: operand_q};
    assign words_o = words_q;

endmodule

// File: source/pim_dma_pkg.sv
package pim_dma_pkg;

    // one bus word, data or byte address
    typedef logic [31:0] word_t;

    // address step between consecutive words
    localparam int unsigned WORD_BYTES = 4;
    // words moved by one parallel transfer
    localparam int unsigned PARALLEL_WORDS = 16;
    // slot index position inside a PIM address
    localparam int unsigned SLOT_SHIFT = 16;

    // remaining word count, wide enough for PARALLEL_WORDS
    typedef logic [4:0] count_t;

    // command opcodes, encodings shared with the PIM mode register
    typedef enum logic [2:0] {
        NO_OP      = 3'd0,
        ERASE      = 3'd1,
        PROGRAM    = 3'd2,
        READ       = 3'd3,
        ZERO_POINT = 3'd4,
        PARALLEL   = 3'd5
    } pim_op_e;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        MODE,
        FETCH,
        STREAM,
        WRITE
    } dma_state_e;

    // per-cycle action on the SRAM port
    typedef enum logic [1:0] {
        SRAM_NONE,
        SRAM_READ,
        SRAM_WRITE
    } sram_act_e;

    // per-cycle action on the PIM port
    typedef enum logic [2:0] {
        PIM_NONE,
        PIM_STATUS_RD,
        PIM_MODE_WR,
        PIM_CMD_WR,
        PIM_DATA_RD,
        PIM_STREAM_WR
    } pim_act_e;

    // accepted command
    typedef struct packed {
        pim_op_e op;
        word_t   rc_addr;
        word_t   operand;
    } dma_cmd_t;

    // outgoing half of a bus port
    typedef struct packed {
        word_t addr;
        logic  write;
        logic  read;
        word_t wr_data;
    } bus_port_t;

endpackage

// File: source/pim_dma_sequencer.sv
module pim_dma_sequencer import pim_dma_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      dma_en_i,
    input  logic      bus_gnt_i,
    input  pim_op_e   op_i,
    input  count_t    words_i,
    input  logic      ready_i,
    input  logic      data_valid_i,
    output logic      start_o,
    output sram_act_e sram_act_o,
    output pim_act_e  pim_act_o,
    output count_t    slot_o,
    output logic      bus_req_o,
    output logic      busy_o
);

    dma_state_e state_q;
    dma_state_e state_d;
    count_t     cnt_q;
    count_t     cnt_d;
    logic       poll_q;
    logic       status_ok;

    // new commands only in IDLE
    assign start_o   = (state_q == IDLE) && dma_en_i;
    assign busy_o    = (state_q != IDLE);
    assign bus_req_o = busy_o;

    // slots count up while the remaining count goes down
    assign slot_o = count_t'(PARALLEL_WORDS) - cnt_q;

    // status word is only trusted if the previous granted cycle polled it
    assign status_ok = poll_q && ready_i && ((op_i != READ) || data_valid_i);

    always_comb begin
        state_d    = state_q;
        cnt_d      = cnt_q;
        sram_act_o = SRAM_NONE;
        pim_act_o  = PIM_NONE;
        case (state_q)
            IDLE: begin
                if (start_o) begin
                    state_d = SETUP;
                end
            end
            SETUP: begin
                if (bus_gnt_i) begin
                    pim_act_o = PIM_STATUS_RD;
                    if (status_ok) begin
                        state_d = MODE;
                    end
                end
            end
            MODE: begin
                if (bus_gnt_i) begin
                    pim_act_o = PIM_MODE_WR;
                    cnt_d     = words_i;
                    case (op_i)
                        ERASE, PROGRAM, ZERO_POINT: state_d = WRITE;
                        READ, PARALLEL: state_d = FETCH;
                        default: state_d = IDLE;
                    endcase
                end
            end
            FETCH: begin
                if (bus_gnt_i) begin
                    if (op_i == READ) begin
                        pim_act_o = PIM_DATA_RD;
                        state_d   = WRITE;
                    end else begin
                        sram_act_o = SRAM_READ;
                        state_d    = STREAM;
                    end
                end
            end
            STREAM: begin
                if (bus_gnt_i) begin
                    pim_act_o = PIM_STREAM_WR;
                    cnt_d     = cnt_q - count_t'(1);
                    // prefetch the next word unless this slot is the last
                    if (cnt_q > count_t'(1)) begin
                        sram_act_o = SRAM_READ;
                    end else begin
                        state_d = IDLE;
                    end
                end
            end
            WRITE: begin
                if (bus_gnt_i) begin
                    if (op_i == READ) begin
                        sram_act_o = SRAM_WRITE;
                    end else begin
                        pim_act_o = PIM_CMD_WR;
                    end
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            poll_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            // remember whether the last granted cycle polled status
            if (bus_gnt_i) begin
                poll_q <= (pim_act_o == PIM_STATUS_RD);
            end
        end
    end

    a_no_act_without_gnt: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !bus_gnt_i |-> (sram_act_o == SRAM_NONE) && (pim_act_o == PIM_NONE)
    );

    a_busy_requests: assert property (
        @(posedge clk_i) disable iff (!rst_ni) busy_o |-> bus_req_o
    );

endmodule

// File: source/pim_dma_top.sv
module pim_dma_top import pim_dma_pkg::*; #(
    parameter word_t PIM_BASE_ADDR   = 32'h4000_0000,
    parameter word_t PIM_MODE_ADDR   = 32'h4100_0000,
    parameter word_t PIM_ZP_ADDR     = 32'h4200_0000,
    parameter word_t PIM_STATUS_ADDR = 32'h4300_0000
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    // command
    input  logic        dma_en_i,
    input  logic [2:0]  funct3_i,
    input  logic [31:0] rs1_i,
    input  logic [31:0] rs2_i,
    // arbitration
    output logic        bus_req_o,
    input  logic        bus_gnt_i,
    // SRAM port
    output logic [31:0] dma_addr_0_o,
    output logic        dma_write_0_o,
    output logic        dma_read_0_o,
    output logic [31:0] dma_wr_data_0_o,
    input  logic [31:0] dma_rd_data_0_i,
    // PIM port
    output logic [31:0] dma_addr_1_o,
    output logic        dma_write_1_o,
    output logic        dma_read_1_o,
    output logic [31:0] dma_wr_data_1_o,
    input  logic [31:0] dma_rd_data_1_i,
    output logic        dma_busy_o
);

    logic      start;
    dma_cmd_t  cmd;
    count_t    words;
    sram_act_e sram_act;
    pim_act_e  pim_act;
    count_t    slot;
    logic      pim_ready;
    logic      pim_data_valid;
    bus_port_t sram_bus;
    bus_port_t pim_bus;

    pim_cmd_capture u_cmd_capture (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .start_i  (start),
        .funct3_i (pim_op_e'(funct3_i)),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .cmd_o    (cmd),
        .words_o  (words)
    );

    pim_dma_sequencer u_sequencer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .dma_en_i     (dma_en_i),
        .bus_gnt_i    (bus_gnt_i),
        .op_i         (cmd.op),
        .words_i      (words),
        .ready_i      (pim_ready),
        .data_valid_i (pim_data_valid),
        .start_o      (start),
        .sram_act_o   (sram_act),
        .pim_act_o    (pim_act),
        .slot_o       (slot),
        .bus_req_o    (bus_req_o),
        .busy_o       (dma_busy_o)
    );

    // PIM read data goes to the SRAM write path
    sram_port u_sram_port (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .start_i       (start),
        .operand_i     (rs2_i),
        .act_i         (sram_act),
        .pim_rd_data_i (dma_rd_data_1_i),
        .port_o        (sram_bus)
    );

    // SRAM read data goes to the PIM write path
    pim_port #(
        .PIM_BASE_ADDR   (PIM_BASE_ADDR),
        .PIM_MODE_ADDR   (PIM_MODE_ADDR),
        .PIM_ZP_ADDR     (PIM_ZP_ADDR),
        .PIM_STATUS_ADDR (PIM_STATUS_ADDR)
    ) u_pim_port (
        .act_i          (pim_act),
        .cmd_i          (cmd),
        .slot_i         (slot),
        .sram_rd_data_i (dma_rd_data_0_i),
        .rd_data_i      (dma_rd_data_1_i),
        .port_o         (pim_bus),
        .ready_o        (pim_ready),
        .data_valid_o   (pim_data_valid)
    );

    assign dma_addr_0_o    = sram_bus.addr;
    assign dma_write_0_o   = sram_bus.write;
    assign dma_read_0_o    = sram_bus.read;
    assign dma_wr_data_0_o = sram_bus.wr_data;

    assign dma_addr_1_o    = pim_bus.addr;
    assign dma_write_1_o   = pim_bus.write;
    assign dma_read_1_o    = pim_bus.read;
    assign dma_wr_data_1_o = pim_bus.wr_data;

endmodule

// File: source/pim_port.sv
module pim_port import pim_dma_pkg::*; #(
    parameter word_t PIM_BASE_ADDR   = 32'h4000_0000,
    parameter word_t PIM_MODE_ADDR   = 32'h4100_0000,
    parameter word_t PIM_ZP_ADDR     = 32'h4200_0000,
    parameter word_t PIM_STATUS_ADDR = 32'h4300_0000
) (
    input  pim_act_e  act_i,
    input  dma_cmd_t  cmd_i,
    input  count_t    slot_i,
    input  word_t     sram_rd_data_i,
    input  word_t     rd_data_i,
    output bus_port_t port_o,
    output logic      ready_o,
    output logic      data_valid_o
);

    word_t cell_addr;
    word_t slot_addr;

    // array cell picked by row/column
    assign cell_addr = PIM_BASE_ADDR + cmd_i.rc_addr;
    // parallel slots sit in the upper half of the address
    assign slot_addr = cell_addr | (word_t'(slot_i) << SLOT_SHIFT);

    always_comb begin
        port_o = '0;
        case (act_i)
            PIM_STATUS_RD: begin
                port_o.addr = PIM_STATUS_ADDR;
                port_o.read = 1'b1;
            end
            PIM_MODE_WR: begin
                port_o.addr    = PIM_MODE_ADDR;
                port_o.write   = 1'b1;
                port_o.wr_data = word_t'(cmd_i.op);
            end
            PIM_CMD_WR: begin
                // zero point has its own register, erase/program hit the cell
                port_o.addr    = (cmd_i.op == ZERO_POINT) ? PIM_ZP_ADDR : cell_addr;
                port_o.write   = 1'b1;
                port_o.wr_data = cmd_i.operand;
            end
            PIM_DATA_RD: begin
                port_o.addr = cell_addr;
                port_o.read = 1'b1;
            end
            PIM_STREAM_WR: begin
                port_o.addr    = slot_addr;
                port_o.write   = 1'b1;
                port_o.wr_data = sram_rd_data_i;
            end
            default: begin
                port_o = '0;
            end
        endcase
    end

    // status word flags
    assign ready_o      = rd_data_i[0];
    assign data_valid_o = rd_data_i[1];

    always_comb begin
        a_pim_rw_excl: assert final (!(port_o.read && port_o.write));
    end

endmodule

// File: source/sram_port.sv
module sram_port import pim_dma_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      start_i,
    input  word_t     operand_i,
    input  sram_act_e act_i,
    input  word_t     pim_rd_data_i,
    output bus_port_t port_o
);

    word_t addr_q;

    // buffer address, one word further after every access
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            addr_q <= '0;
        end else if (start_i) begin
            addr_q <= operand_i;
        end else if (act_i != SRAM_NONE) begin
            addr_q <= addr_q + word_t'(WORD_BYTES);
        end
    end

    always_comb begin
        port_o.addr    = addr_q;
        port_o.read    = (act_i == SRAM_READ);
        port_o.write   = (act_i == SRAM_WRITE);
        // SRAM only ever receives words read from the PIM
        port_o.wr_data = port_o.write ? pim_rd_data_i : '0;
    end

    a_sram_rw_excl: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(port_o.read && port_o.write)
    );

endmodule

// File: sources.f
source/pim_dma_pkg.sv
source/pim_cmd_capture.sv
source/sram_port.sv
source/pim_port.sv
source/pim_dma_sequencer.sv
source/pim_dma_top.sv
verification/tb_pim_dma.sv

// File: verification/tb_pim_dma.sv
module tb_pim_dma import pim_dma_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t BASE_ADDR   = 32'h4000_0000;
    localparam word_t MODE_ADDR   = 32'h4100_0000;
    localparam word_t ZP_ADDR     = 32'h4200_0000;
    localparam word_t STATUS_ADDR = 32'h4300_0000;
    localparam int    TIMEOUT     = 200;
    // SRAM buffer of the read test
    localparam word_t BUF_ADDR    = 32'h0000_0100;

    logic       clk_i = 1'b0;
    logic       rst_ni;
    logic       dma_en_i;
    logic [2:0] funct3_i;
    word_t      rs1_i;
    word_t      rs2_i;
    logic       bus_req_o;
    logic       bus_gnt_i = 1'b0;
    word_t      dma_addr_0_o;
    logic       dma_write_0_o;
    logic       dma_read_0_o;
    word_t      dma_wr_data_0_o;
    word_t      dma_addr_1_o;
    logic       dma_write_1_o;
    logic       dma_read_1_o;
    word_t      dma_wr_data_1_o;
    logic       dma_busy_o;

    // bus models
    word_t      sram_mem [0:1023];
    word_t      sram_rd_q = '0;
    word_t      pim_rd_q = '0;
    word_t      pim_status;
    bus_port_t  pim_log[$];
    bus_port_t  sram_log[$];

    logic       drop_en;
    word_t      lcg_state = 32'd2;
    int         value_errs = 0;
    int         other_errs = 0;

    pim_dma_top DUT (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .dma_en_i        (dma_en_i),
        .funct3_i        (funct3_i),
        .rs1_i           (rs1_i),
        .rs2_i           (rs2_i),
        .bus_req_o       (bus_req_o),
        .bus_gnt_i       (bus_gnt_i),
        .dma_addr_0_o    (dma_addr_0_o),
        .dma_write_0_o   (dma_write_0_o),
        .dma_read_0_o    (dma_read_0_o),
        .dma_wr_data_0_o (dma_wr_data_0_o),
        .dma_rd_data_0_i (sram_rd_q),
        .dma_addr_1_o    (dma_addr_1_o),
        .dma_write_1_o   (dma_write_1_o),
        .dma_read_1_o    (dma_read_1_o),
        .dma_wr_data_1_o (dma_wr_data_1_o),
        .dma_rd_data_1_i (pim_rd_q),
        .dma_busy_o      (dma_busy_o)
    );

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // content of a PIM cell, tied to the full address
    function automatic word_t cell_word(word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic bus_port_t wr_entry(word_t addr, word_t data);
        return '{addr: addr, write: 1'b1, read: 1'b0, wr_data: data};
    endfunction

    initial begin
        forever #5 clk_i = ~clk_i;
    end

    // grant follows request, with random drops when enabled
    always @(negedge clk_i) begin
        word_t r;
        r = drop_en ? next_rand() : '1;
        bus_gnt_i <= bus_req_o && (r[17:16] != 2'b00);
    end

    always @(posedge clk_i) begin
        if (!bus_gnt_i && (dma_read_0_o || dma_write_0_o || dma_read_1_o || dma_write_1_o)) begin
            $display("bus strobe active while the grant is low at %0t ns", $time);
            other_errs++;
        end
        if (bus_gnt_i && dma_read_0_o) begin
            sram_rd_q <= sram_mem[dma_addr_0_o[11:2]];
        end
        if (bus_gnt_i && dma_write_0_o) begin
            sram_mem[dma_addr_0_o[11:2]] <= dma_wr_data_0_o;
            sram_log.push_back('{addr: dma_addr_0_o, write: dma_write_0_o,
                                 read: dma_read_0_o, wr_data: dma_wr_data_0_o});
        end
        if (bus_gnt_i && dma_read_1_o) begin
            pim_rd_q <= (dma_addr_1_o == STATUS_ADDR) ? pim_status : cell_word(dma_addr_1_o);
        end
        if (bus_gnt_i && dma_write_1_o) begin
            pim_log.push_back('{addr: dma_addr_1_o, write: dma_write_1_o,
                                read: dma_read_1_o, wr_data: dma_wr_data_1_o});
        end
    end

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_port(input string what, input bus_port_t got, input bus_port_t exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s is %h w%b r%b data %h, expected %h w%b r%b data %h",
                     $time, what, got.addr, got.write, got.read, got.wr_data,
                     exp.addr, exp.write, exp.read, exp.wr_data);
            value_errs++;
        end
    endtask

    task automatic check_log(input string what, input bus_port_t got[$], input bus_port_t exp[$]);
        check_word({what, " write count"}, word_t'(got.size()), word_t'(exp.size()));
        for (int i = 0; i < exp.size() && i < got.size(); i++) begin
            check_port($sformatf("%s write %0d", what, i), got[i], exp[i]);
        end
    endtask

    task automatic start_cmd(input pim_op_e op, input word_t rs1, input word_t rs2);
        @(negedge clk_i);
        dma_en_i = 1'b1;
        funct3_i = op;
        rs1_i    = rs1;
        rs2_i    = rs2;
        @(negedge clk_i);
        dma_en_i = 1'b0;
        check_word("busy after accept", word_t'(dma_busy_o), 32'd1);
        check_word("request after accept", word_t'(bus_req_o), 32'd1);
    endtask

    task automatic wait_idle(input string what);
        int n = 0;
        while (dma_busy_o && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (dma_busy_o) begin
            $display("timeout: %s still busy after %0d cycles", what, TIMEOUT);
            other_errs++;
        end
    endtask

    task automatic test_reset_state();
        check_word("busy after reset", word_t'(dma_busy_o), 32'd0);
        check_word("request after reset", word_t'(bus_req_o), 32'd0);
        check_word("sram strobes after reset", word_t'({dma_read_0_o, dma_write_0_o}), 32'd0);
        check_word("pim strobes after reset", word_t'({dma_read_1_o, dma_write_1_o}), 32'd0);
    endtask

    // erase, program and zero point: mode write then one command write
    task automatic test_single_write(input string name, input pim_op_e op, input word_t rs1,
                                     input word_t rs2, input word_t dest);
        bus_port_t exp[$];
        pim_log.delete();
        pim_status = 32'h1;
        start_cmd(op, rs1, rs2);
        wait_idle(name);
        exp.push_back(wr_entry(MODE_ADDR, word_t'(op)));
        exp.push_back(wr_entry(dest, rs2));
        check_log(name, pim_log, exp);
    endtask

    task automatic test_read();
        bus_port_t exp_pim[$];
        bus_port_t exp_sram[$];
        word_t     data;
        data = cell_word(BASE_ADDR + 32'h30);
        pim_log.delete();
        sram_log.delete();
        // ready without data valid must stall the poll
        pim_status = 32'h1;
        start_cmd(READ, 32'h30, BUF_ADDR);
        repeat (20) @(negedge clk_i);
        check_word("busy while data invalid", word_t'(dma_busy_o), 32'd1);
        check_word("pim writes while data invalid", word_t'(pim_log.size()), 32'd0);
        pim_status = 32'h3;
        wait_idle("read");
        exp_pim.push_back(wr_entry(MODE_ADDR, word_t'(READ)));
        exp_sram.push_back(wr_entry(BUF_ADDR, data));
        check_log("read pim", pim_log, exp_pim);
        check_log("read sram", sram_log, exp_sram);
        check_word("sram word after read", sram_mem[BUF_ADDR[11:2]], data);
    endtask

    task automatic test_parallel(input string name, input word_t rs1, input word_t src,
                                 input logic drops);
        bus_port_t exp[$];
        word_t     src_addr;
        word_t     dst_addr;
        pim_log.delete();
        pim_status = 32'h1;
        exp.push_back(wr_entry(MODE_ADDR, word_t'(PARALLEL)));
        for (int k = 0; k < PARALLEL_WORDS; k++) begin
            src_addr = src + word_t'(k * WORD_BYTES);
            dst_addr = (BASE_ADDR + rs1) | (word_t'(k) << SLOT_SHIFT);
            exp.push_back(wr_entry(dst_addr, sram_mem[src_addr[11:2]]));
        end
        drop_en = drops;
        start_cmd(PARALLEL, rs1, src);
        wait_idle(name);
        drop_en = 1'b0;
        check_log(name, pim_log, exp);
    endtask

    initial begin
        rst_ni     = 1'b0;
        dma_en_i   = 1'b0;
        funct3_i   = '0;
        rs1_i      = '0;
        rs2_i      = '0;
        pim_status = '0;
        drop_en    = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            sram_mem[i] = next_rand();
        end
        repeat (5) @(negedge clk_i);
        rst_ni = 1'b1;

        test_reset_state();
        test_single_write("program", PROGRAM, 32'h24, 32'h0000_1234, BASE_ADDR + 32'h24);
        test_single_write("erase", ERASE, 32'h88, 32'h0000_0077, BASE_ADDR + 32'h88);
        test_single_write("zero point", ZERO_POINT, 32'h10, 32'h0000_0042, ZP_ADDR);
        test_read();
        test_parallel("parallel", 32'h40, 32'h0000_0200, 1'b0);
        test_parallel("parallel with drops", 32'h80, 32'h0000_0300, 1'b1);

        repeat (2) @(negedge clk_i);
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
